// ==== logic/ExecPkg.sv ====
package ExecPkg;

    // Function unit that executes a micro-op
    typedef enum logic [0:0] {
        FU_INT,
        FU_MUL
    } FuncUnit;

    // Operations understood by the execute stage
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        // Signed compare, result is 0 or 1
        OP_SLT,
        // Shift amount is srcB[4:0]
        OP_SLL,
        // Low 32 bits of the product
        OP_MUL
    } Opcode;

    // One enable bit per execution unit
    localparam int NUM_XUS = 2;
    localparam int XU_INT = 0;
    localparam int XU_MUL = 1;

endpackage

// ==== logic/UopPkg.sv ====
package UopPkg;

    import ExecPkg::*;

    // Micro-op as it leaves the issue stage
    typedef struct packed {
        logic [31:0] imm;
        logic [31:0] pc;

        // Source A, may be replaced by the pc
        logic availA;
        logic [5:0] tagA;
        logic pcA;

        // Source B, may be replaced by the immediate
        logic availB;
        logic [5:0] tagB;
        logic immB;

        logic [5:0] sqN;
        logic [5:0] tagDst;
        logic [4:0] nmDst;
        Opcode opcode;
        FuncUnit fu;
    } R_UOp;

    // Micro-op with resolved operands, input of the execute stage
    typedef struct packed {
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] imm;
        logic [5:0] sqN;
        logic [5:0] tagDst;
        logic [4:0] nmDst;
        Opcode opcode;
        logic valid;
    } EX_UOp;

endpackage

// ==== logic/WritebackIf.sv ====
interface WritebackIf #(
    parameter int NUM_UOPS = 2
);

    // One writeback slot per lane, a slot is live when its valid bit is high
    logic valid[NUM_UOPS-1:0];
    logic [5:0] tag[NUM_UOPS-1:0];
    logic [5:0] sqN[NUM_UOPS-1:0];
    logic [31:0] result[NUM_UOPS-1:0];

    // Driven by the execute stage
    modport source (
        output valid,
        output tag,
        output sqN,
        output result
    );

    // Register file write and operand bypass
    modport sink (
        input valid,
        input tag,
        input sqN,
        input result
    );

endinterface

// ==== logic/RegFile.sv ====
module RegFile #(
    parameter int NUM_UOPS = 2
) (
    input  logic clk,
    input  logic rst,

    // Port i is source A of lane i, port i+NUM_UOPS is source B
    input  logic rfReadValid[2*NUM_UOPS-1:0],
    input  logic [5:0] rfReadAddr[2*NUM_UOPS-1:0],
    output logic [31:0] rfReadData[2*NUM_UOPS-1:0],

    WritebackIf.sink wb
);

    logic [31:0] regs[63:0];

    // Asynchronous read, an idle port reads as zero
    always_comb begin
        for (int i = 0; i < 2*NUM_UOPS; i++) begin
            if (rfReadValid[i]) begin
                rfReadData[i] = regs[rfReadAddr[i]];
            end
            else begin
                rfReadData[i] = 32'h0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 64; r++) begin
                regs[r] <= 32'h0;
            end
        end
        else begin
            // Later lanes overwrite earlier ones on a tag clash
            for (int i = 0; i < NUM_UOPS; i++) begin
                if (wb.valid[i]) begin
                    regs[wb.tag[i]] <= wb.result[i];
                end
            end
        end
    end

endmodule

// ==== logic/OperandLoad.sv ====
module OperandLoad
    import ExecPkg::*;
    import UopPkg::*;
#(
    parameter int NUM_UOPS = 2
) (
    input  logic clk,
    input  logic rst,

    input  logic uopValid[NUM_UOPS-1:0],
    input  R_UOp uop[NUM_UOPS-1:0],

    // Writeback contention, a stalled lane keeps its output
    input  logic wbStall[NUM_UOPS-1:0],

    // Branch flush, everything younger than invalidateSqN is dropped
    input  logic invalidate,
    input  logic [5:0] invalidateSqN,

    output logic rfReadValid[2*NUM_UOPS-1:0],
    output logic [5:0] rfReadAddr[2*NUM_UOPS-1:0],
    input  logic [31:0] rfReadData[2*NUM_UOPS-1:0],

    WritebackIf.sink wb,

    output EX_UOp exUop[NUM_UOPS-1:0],
    output logic [NUM_XUS-1:0] enableXU[NUM_UOPS-1:0]
);

    logic [31:0] operandA[NUM_UOPS-1:0];
    logic [31:0] operandB[NUM_UOPS-1:0];

    // Sequence numbers wrap, so compare through the signed difference
    function automatic logic isYounger(input logic [5:0] sqN, input logic [5:0] flushSqN);
        logic signed [5:0] delta;
        delta = $signed(sqN - flushSqN);
        return delta > 0;
    endfunction

    function automatic logic [NUM_XUS-1:0] unitMask(input FuncUnit fu);
        logic [NUM_XUS-1:0] mask;
        mask = '0;
        case (fu)
            FU_INT: mask[XU_INT] = 1'b1;
            FU_MUL: mask[XU_MUL] = 1'b1;
            default: mask = '0;
        endcase
        return mask;
    endfunction

    // Register file request straight from the issued tags
    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            rfReadValid[i] = uop[i].availA;
            rfReadAddr[i] = uop[i].tagA;
            rfReadValid[i+NUM_UOPS] = uop[i].availB;
            rfReadAddr[i+NUM_UOPS] = uop[i].tagB;
        end
    end

    // Operand select: pc/imm first, then the bypass, then the register file
    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            operandA[i] = rfReadData[i];
            operandB[i] = rfReadData[i+NUM_UOPS];

            // Walk down so the lowest matching slot is the one that sticks
            for (int j = NUM_UOPS - 1; j >= 0; j--) begin
                if (wb.valid[j] && wb.tag[j] == uop[i].tagA) begin
                    operandA[i] = wb.result[j];
                end
                if (wb.valid[j] && wb.tag[j] == uop[i].tagB) begin
                    operandB[i] = wb.result[j];
                end
            end

            if (uop[i].pcA) begin
                operandA[i] = uop[i].pc;
            end
            if (uop[i].immB) begin
                operandB[i] = uop[i].imm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                exUop[i].valid <= 1'b0;
                enableXU[i] <= '0;
            end
        end
        else begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                if (!wbStall[i] && uopValid[i]) begin
                    exUop[i].srcA <= operandA[i];
                    exUop[i].srcB <= operandB[i];
                    exUop[i].imm <= uop[i].imm;
                    exUop[i].sqN <= uop[i].sqN;
                    exUop[i].tagDst <= uop[i].tagDst;
                    exUop[i].nmDst <= uop[i].nmDst;
                    exUop[i].opcode <= uop[i].opcode;
                    exUop[i].valid <= !(invalidate && isYounger(uop[i].sqN, invalidateSqN));
                    enableXU[i] <= unitMask(uop[i].fu);
                end
                else if (!wbStall[i]) begin
                    // Bubble
                    exUop[i].valid <= 1'b0;
                    enableXU[i] <= '0;
                end
            end
        end
    end

endmodule

// ==== logic/ExecUnit.sv ====
module ExecUnit
    import ExecPkg::*;
    import UopPkg::*;
#(
    parameter int NUM_UOPS = 2
) (
    input  logic clk,
    input  logic rst,

    input  EX_UOp exUop[NUM_UOPS-1:0],
    input  logic [NUM_XUS-1:0] enableXU[NUM_UOPS-1:0],
    input  logic wbStall[NUM_UOPS-1:0],

    WritebackIf.source wb,

    // Architectural destination, registered alongside the writeback slot
    output logic [4:0] nmDst[NUM_UOPS-1:0]
);

    logic [31:0] aluResult[NUM_UOPS-1:0];
    logic [31:0] mulResult[NUM_UOPS-1:0];

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            case (exUop[i].opcode)
                OP_ADD: aluResult[i] = exUop[i].srcA + exUop[i].srcB;
                OP_SUB: aluResult[i] = exUop[i].srcA - exUop[i].srcB;
                OP_AND: aluResult[i] = exUop[i].srcA & exUop[i].srcB;
                OP_OR: aluResult[i] = exUop[i].srcA | exUop[i].srcB;
                OP_XOR: aluResult[i] = exUop[i].srcA ^ exUop[i].srcB;
                OP_SLT: begin
                    aluResult[i] = {31'b0, $signed(exUop[i].srcA) < $signed(exUop[i].srcB)};
                end
                OP_SLL: aluResult[i] = exUop[i].srcA << exUop[i].srcB[4:0];
                default: aluResult[i] = 32'h0;
            endcase

            // 32-bit context keeps only the low half of the product
            mulResult[i] = exUop[i].srcA * exUop[i].srcB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                wb.valid[i] <= 1'b0;
            end
        end
        else begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                if (wbStall[i]) begin
                    // Payload holds, only the valid bit drops
                    wb.valid[i] <= 1'b0;
                end
                else begin
                    wb.valid[i] <= exUop[i].valid && (|enableXU[i]);
                    wb.tag[i] <= exUop[i].tagDst;
                    wb.sqN[i] <= exUop[i].sqN;
                    nmDst[i] <= exUop[i].nmDst;
                    if (enableXU[i][XU_MUL]) begin
                        wb.result[i] <= mulResult[i];
                    end
                    else if (enableXU[i][XU_INT]) begin
                        wb.result[i] <= aluResult[i];
                    end
                end
            end
        end
    end

endmodule

// ==== logic/ExecCluster.sv ====
module ExecCluster
    import ExecPkg::*;
    import UopPkg::*;
#(
    parameter int NUM_UOPS = 2
) (
    input  logic clk,
    input  logic rst,

    // Issue side, one slot per lane
    input  logic issueValid[NUM_UOPS-1:0],
    input  R_UOp issueUop[NUM_UOPS-1:0],
    input  logic wbStall[NUM_UOPS-1:0],

    input  logic invalidate,
    input  logic [5:0] invalidateSqN,

    // Results as seen on the writeback bus
    output logic resValid[NUM_UOPS-1:0],
    output logic [5:0] resTag[NUM_UOPS-1:0],
    output logic [5:0] resSqN[NUM_UOPS-1:0],
    output logic [4:0] resNmDst[NUM_UOPS-1:0],
    output logic [31:0] resResult[NUM_UOPS-1:0]
);

    logic rfReadValid[2*NUM_UOPS-1:0];
    logic [5:0] rfReadAddr[2*NUM_UOPS-1:0];
    logic [31:0] rfReadData[2*NUM_UOPS-1:0];

    EX_UOp exUop[NUM_UOPS-1:0];
    logic [NUM_XUS-1:0] enableXU[NUM_UOPS-1:0];

    WritebackIf #(.NUM_UOPS(NUM_UOPS)) wbBus ();

    RegFile #(.NUM_UOPS(NUM_UOPS)) regFile (
        .clk(clk),
        .rst(rst),
        .rfReadValid(rfReadValid),
        .rfReadAddr(rfReadAddr),
        .rfReadData(rfReadData),
        .wb(wbBus.sink)
    );

    OperandLoad #(.NUM_UOPS(NUM_UOPS)) operandLoad (
        .clk(clk),
        .rst(rst),
        .uopValid(issueValid),
        .uop(issueUop),
        .wbStall(wbStall),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .rfReadValid(rfReadValid),
        .rfReadAddr(rfReadAddr),
        .rfReadData(rfReadData),
        .wb(wbBus.sink),
        .exUop(exUop),
        .enableXU(enableXU)
    );

    ExecUnit #(.NUM_UOPS(NUM_UOPS)) execUnit (
        .clk(clk),
        .rst(rst),
        .exUop(exUop),
        .enableXU(enableXU),
        .wbStall(wbStall),
        .wb(wbBus.source),
        .nmDst(resNmDst)
    );

    for (genvar g = 0; g < NUM_UOPS; g++) begin : genRes
        assign resValid[g] = wbBus.valid[g];
        assign resTag[g] = wbBus.tag[g];
        assign resSqN[g] = wbBus.sqN[g];
        assign resResult[g] = wbBus.result[g];
    end

endmodule

// ==== testbench/ExecCluster_properties.sv ====
module OperandLoadProperties
    import ExecPkg::*;
    import UopPkg::*;
#(
    parameter int NUM_UOPS = 2
) (
    input logic clk,
    input logic rst,
    input logic wbStall[NUM_UOPS-1:0],
    input EX_UOp exUop[NUM_UOPS-1:0],
    input logic [NUM_XUS-1:0] enableXU[NUM_UOPS-1:0]
);

    for (genvar g = 0; g < NUM_UOPS; g++) begin : genLane
        // Unit enables are cleared by the second reset cycle
        assert property (@(posedge clk) rst && $past(rst) |-> enableXU[g] == '0)
            else $error("enableXU not zero during reset on lane %0d", g);

        assert property (@(posedge clk) disable iff (rst) $onehot0(enableXU[g]))
            else $error("enableXU not one-hot on lane %0d", g);

        // A stalled lane holds its whole output
        assert property (@(posedge clk) disable iff (rst)
                wbStall[g] |=> $stable(exUop[g]) && $stable(enableXU[g]))
            else $error("stalled lane %0d changed its output", g);
    end

endmodule

bind OperandLoad OperandLoadProperties #(.NUM_UOPS(NUM_UOPS)) props (
    .clk(clk),
    .rst(rst),
    .wbStall(wbStall),
    .exUop(exUop),
    .enableXU(enableXU)
);

// ==== testbench/ExecClusterTb.sv ====
module ExecClusterTb
    import ExecPkg::*;
    import UopPkg::*;
;

    localparam int NUM_LANES = 2;
    localparam int NUM_ROWS = 24;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 4;

    // One lane of one table row
    typedef struct packed {
        logic v;
        Opcode op;
        logic pcA;
        logic immB;
        logic [5:0] tagA;
        logic [5:0] tagB;
        logic [5:0] tagDst;
        logic [5:0] sqN;
        logic stall;
        logic [31:0] pc;
    } LaneRow;

    logic clk;
    logic rst;
    logic issueValid[NUM_LANES-1:0];
    R_UOp issueUop[NUM_LANES-1:0];
    logic wbStall[NUM_LANES-1:0];
    logic invalidate;
    logic [5:0] invalidateSqN;
    logic resValid[NUM_LANES-1:0];
    logic [5:0] resTag[NUM_LANES-1:0];
    logic [5:0] resSqN[NUM_LANES-1:0];
    logic [4:0] resNmDst[NUM_LANES-1:0];
    logic [31:0] resResult[NUM_LANES-1:0];

    LaneRow laneTab[NUM_ROWS][NUM_LANES];
    logic flushTab[NUM_ROWS];
    logic [5:0] flushSqTab[NUM_ROWS];
    integer seed;

    // Reference state: register contents and the two pipeline stages per lane
    logic [31:0] modelRegs[64];
    logic [31:0] pendRes[NUM_LANES];
    logic [5:0] pendTag[NUM_LANES];
    logic [5:0] pendSqN[NUM_LANES];
    logic stageValid[NUM_LANES];
    logic [31:0] stageRes[NUM_LANES];
    logic [5:0] stageTag[NUM_LANES];
    logic [5:0] stageSqN[NUM_LANES];
    logic expValid[NUM_LANES];
    logic [31:0] expRes[NUM_LANES];
    logic [5:0] expTag[NUM_LANES];
    logic [5:0] expSqN[NUM_LANES];

    ExecCluster #(.NUM_UOPS(NUM_LANES)) UUT (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueUop(issueUop),
        .wbStall(wbStall),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .resValid(resValid),
        .resTag(resTag),
        .resSqN(resSqN),
        .resNmDst(resNmDst),
        .resResult(resResult)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERROR @%0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] refResult(input Opcode op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR: return a | b;
            OP_XOR: return a ^ b;
            OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLL: return a << b[4:0];
            OP_MUL: return a * b;
            default: return 32'h0;
        endcase
    endfunction

    // Younger than the flush point means a positive wrapped distance
    function automatic logic flushedBy(input logic [5:0] sq, input logic [5:0] flushSq);
        logic [5:0] diff;
        diff = sq - flushSq;
        return (diff != 6'd0) && !diff[5];
    endfunction

    task automatic driveRow(input int r);
        LaneRow row;
        R_UOp uop;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        for (int l = 0; l < NUM_LANES; l++) begin
            row = laneTab[r][l];
            uop = '0;
            if (row.v) begin
                imm = $random(seed);
                uop.imm = imm;
                uop.pc = row.pc;
                uop.availA = !row.pcA;
                uop.tagA = row.tagA;
                uop.pcA = row.pcA;
                uop.availB = !row.immB;
                uop.tagB = row.tagB;
                uop.immB = row.immB;
                uop.sqN = row.sqN;
                uop.tagDst = row.tagDst;
                uop.nmDst = row.tagDst[4:0];
                uop.opcode = row.op;
                uop.fu = (row.op == OP_MUL) ? FU_MUL : FU_INT;
                a = row.pcA ? row.pc : modelRegs[row.tagA];
                b = row.immB ? imm : modelRegs[row.tagB];
                pendRes[l] = refResult(row.op, a, b);
                pendTag[l] = row.tagDst;
                pendSqN[l] = row.sqN;
            end
            issueValid[l] = row.v;
            issueUop[l] = uop;
            wbStall[l] = row.stall;
        end
        invalidate = flushTab[r];
        invalidateSqN = flushSqTab[r];
    endtask

    // Advance the reference pipeline over the edge that took row r, then compare
    task automatic stepAndCheck(input int r);
        LaneRow row;
        for (int l = 0; l < NUM_LANES; l++) begin
            row = laneTab[r][l];
            expValid[l] = 1'b0;
            if (!row.stall) begin
                expValid[l] = stageValid[l];
                expRes[l] = stageRes[l];
                expTag[l] = stageTag[l];
                expSqN[l] = stageSqN[l];
                stageValid[l] = 1'b0;
                if (row.v) begin
                    stageValid[l] = !(flushTab[r] && flushedBy(row.sqN, flushSqTab[r]));
                    stageRes[l] = pendRes[l];
                    stageTag[l] = pendTag[l];
                    stageSqN[l] = pendSqN[l];
                end
            end
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            checkEqual({31'b0, resValid[l]}, {31'b0, expValid[l]},
                       $sformatf("row %0d lane %0d valid", r, l));
            if (expValid[l]) begin
                checkEqual({26'b0, resTag[l]}, {26'b0, expTag[l]}, "tag");
                checkEqual({26'b0, resSqN[l]}, {26'b0, expSqN[l]}, "sqN");
                checkEqual({27'b0, resNmDst[l]}, {27'b0, expTag[l][4:0]}, "nmDst");
                checkEqual(resResult[l], expRes[l],
                           $sformatf("row %0d lane %0d result", r, l));
                modelRegs[expTag[l]] = expRes[l];
            end
        end
    endtask

    task automatic fillTable();
        for (int r = 0; r < NUM_ROWS; r++) begin
            laneTab[r][0] = '0;
            laneTab[r][1] = '0;
            flushTab[r] = 1'b0;
            flushSqTab[r] = 6'd0;
        end
        // Constants from pc plus immediate
        laneTab[0][0] = '{1'b1, OP_ADD, 1'b1, 1'b1, 6'd0, 6'd0, 6'd1, 6'd1, 1'b0, 32'h100};
        laneTab[0][1] = '{1'b1, OP_ADD, 1'b1, 1'b1, 6'd0, 6'd0, 6'd2, 6'd2, 1'b0, 32'h3};
        laneTab[1][0] = '{1'b1, OP_ADD, 1'b1, 1'b1, 6'd0, 6'd0, 6'd3, 6'd3, 1'b0, 32'h55};
        laneTab[1][1] = '{1'b1, OP_ADD, 1'b1, 1'b1, 6'd0, 6'd0, 6'd4, 6'd4, 1'b0, 32'h80000000};
        // A negative and a positive constant, pc plus the zero register
        laneTab[2][0] = '{1'b1, OP_ADD, 1'b1, 1'b0, 6'd0, 6'd0, 6'd27, 6'd27, 1'b0, 32'h80000000};
        laneTab[2][1] = '{1'b1, OP_ADD, 1'b1, 1'b0, 6'd0, 6'd0, 6'd28, 6'd28, 1'b0, 32'h7};
        // Every opcode from the register file
        laneTab[4][0] = '{1'b1, OP_ADD, 1'b0, 1'b0, 6'd1, 6'd2, 6'd5, 6'd5, 1'b0, 32'h0};
        laneTab[4][1] = '{1'b1, OP_SUB, 1'b0, 1'b0, 6'd1, 6'd2, 6'd6, 6'd6, 1'b0, 32'h0};
        laneTab[5][0] = '{1'b1, OP_AND, 1'b0, 1'b0, 6'd3, 6'd4, 6'd7, 6'd7, 1'b0, 32'h0};
        laneTab[5][1] = '{1'b1, OP_OR, 1'b0, 1'b0, 6'd3, 6'd4, 6'd8, 6'd8, 1'b0, 32'h0};
        laneTab[6][0] = '{1'b1, OP_XOR, 1'b0, 1'b0, 6'd1, 6'd3, 6'd9, 6'd9, 1'b0, 32'h0};
        // Negative against positive, only a signed compare gives 1
        laneTab[6][1] = '{1'b1, OP_SLT, 1'b0, 1'b0, 6'd27, 6'd28, 6'd10, 6'd10, 1'b0, 32'h0};
        laneTab[7][0] = '{1'b1, OP_SLL, 1'b0, 1'b0, 6'd1, 6'd2, 6'd11, 6'd11, 1'b0, 32'h0};
        laneTab[7][1] = '{1'b1, OP_MUL, 1'b0, 1'b0, 6'd3, 6'd4, 6'd12, 6'd12, 1'b0, 32'h0};
        // Bypass two cycles after the producers, same lane and crossed
        laneTab[8][0] = '{1'b1, OP_ADD, 1'b0, 1'b0, 6'd9, 6'd10, 6'd13, 6'd13, 1'b0, 32'h0};
        laneTab[8][1] = '{1'b1, OP_SUB, 1'b0, 1'b0, 6'd10, 6'd9, 6'd14, 6'd14, 1'b0, 32'h0};
        laneTab[9][0] = '{1'b1, OP_MUL, 1'b0, 1'b0, 6'd11, 6'd12, 6'd15, 6'd15, 1'b0, 32'h0};
        laneTab[9][1] = '{1'b1, OP_SLT, 1'b0, 1'b0, 6'd12, 6'd11, 6'd16, 6'd16, 1'b0, 32'h0};
        // Writeback stall on lane 0, the offers during the stall are lost
        laneTab[10][0] = '{1'b1, OP_ADD, 1'b0, 1'b0, 6'd1, 6'd2, 6'd17, 6'd17, 1'b0, 32'h0};
        laneTab[11][0] = '{1'b1, OP_ADD, 1'b0, 1'b1, 6'd1, 6'd0, 6'd18, 6'd18, 1'b1, 32'h0};
        laneTab[12][0] = '{1'b1, OP_XOR, 1'b0, 1'b1, 6'd2, 6'd0, 6'd18, 6'd19, 1'b1, 32'h0};
        laneTab[12][1] = '{1'b1, OP_XOR, 1'b0, 1'b0, 6'd3, 6'd4, 6'd19, 6'd20, 1'b0, 32'h0};
        laneTab[15][0] = '{1'b1, OP_ADD, 1'b0, 1'b0, 6'd18, 6'd17, 6'd20, 6'd21, 1'b0, 32'h0};
        // Branch flush at sqN 40
        laneTab[16][0] = '{1'b1, OP_ADD, 1'b0, 1'b0, 6'd1, 6'd2, 6'd21, 6'd39, 1'b0, 32'h0};
        laneTab[16][1] = '{1'b1, OP_ADD, 1'b0, 1'b1, 6'd1, 6'd0, 6'd22, 6'd41, 1'b0, 32'h0};
        laneTab[17][0] = '{1'b1, OP_MUL, 1'b0, 1'b1, 6'd3, 6'd0, 6'd23, 6'd42, 1'b0, 32'h0};
        laneTab[17][1] = '{1'b1, OP_SUB, 1'b0, 1'b0, 6'd3, 6'd1, 6'd24, 6'd40, 1'b0, 32'h0};
        flushTab[16] = 1'b1;
        flushSqTab[16] = 6'd40;
        flushTab[17] = 1'b1;
        flushSqTab[17] = 6'd40;
        laneTab[20][0] = '{1'b1, OP_ADD, 1'b0, 1'b0, 6'd22, 6'd1, 6'd25, 6'd43, 1'b0, 32'h0};
        laneTab[20][1] = '{1'b1, OP_ADD, 1'b0, 1'b0, 6'd23, 6'd24, 6'd26, 6'd44, 1'b0, 32'h0};
    endtask

    // Watchdog
    initial begin
        #((NUM_ROWS + 20) * CLK_PERIOD);
        $display("Watchdog expired before the table finished running");
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        seed = 32'h612cd5d5;
        invalidate = 1'b0;
        invalidateSqN = 6'd0;
        for (int l = 0; l < NUM_LANES; l++) begin
            issueValid[l] = 1'b0;
            issueUop[l] = '0;
            wbStall[l] = 1'b0;
            stageValid[l] = 1'b0;
        end
        for (int i = 0; i < 64; i++) begin
            modelRegs[i] = 32'h0;
        end
        fillTable();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            checkEqual({31'b0, resValid[l]}, 32'h0, "valid right after reset");
        end

        driveRow(0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            #1;
            stepAndCheck(r);
            if (r + 1 < NUM_ROWS) begin
                driveRow(r + 1);
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== ExecCluster.f ====
logic/ExecPkg.sv
logic/UopPkg.sv
logic/WritebackIf.sv
logic/RegFile.sv
logic/OperandLoad.sv
logic/ExecUnit.sv
logic/ExecCluster.sv
testbench/ExecCluster_properties.sv
testbench/ExecClusterTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the ExecCluster testbench with Verilator
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert \
    --top-module ExecClusterTb \
    -Mdir build/obj \
    -f ExecCluster.f

# The simulator exits non-zero on a fatal check, the log decides the verdict
./build/obj/VExecClusterTb > build/sim.log 2>&1 || true
cat build/sim.log

if grep -q '\*\* FAIL \*\*' build/sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' build/sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation passed"
